// ==== hdl/eeprom_pkg.sv ====
package eeprom_pkg;

    typedef logic [10:0] ee_addr_t;   // 2 KB byte address
    typedef logic [7:0]  ee_byte_t;

    // one master's request
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        ee_addr_t adr;
        ee_byte_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        logic     err;
        ee_byte_t dat;
    } wb_rsp_t;

    // CMD_START doubles as the repeated start
    typedef enum logic [1:0] {
        CMD_START,
        CMD_WRITE,
        CMD_READ,
        CMD_STOP
    } i2c_cmd_e;

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_W,
        RESTART,
        CTRL_R,
        DATA_R,
        STOP,
        DONE
    } ctrl_state_e;

    localparam logic [3:0] EE_DEV_CODE = 4'b1010;   // control byte prefix

endpackage

// ==== hdl/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                CLK,
    input  logic                RESET,
    input  eeprom_pkg::wb_req_t m0_req,
    input  eeprom_pkg::wb_req_t m1_req,
    output eeprom_pkg::wb_rsp_t m0_rsp,
    output eeprom_pkg::wb_rsp_t m1_rsp,
    output eeprom_pkg::wb_req_t s_req,
    input  eeprom_pkg::wb_rsp_t s_rsp
);

    logic gnt_valid;
    logic gnt_sel;      // 0 = m0, 1 = m1
    logic last_sel;     // master served last
    logic req0;
    logic req1;

    assign req0 = m0_req.cyc && m0_req.stb;
    assign req1 = m1_req.cyc && m1_req.stb;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            gnt_valid <= 1'b0;
            gnt_sel   <= 1'b0;
            last_sel  <= 1'b1;
        end
        else if (!gnt_valid)
        begin
            if (req0 && req1)
            begin
                // tie goes to whoever waited
                gnt_valid <= 1'b1;
                gnt_sel   <= !last_sel;
                last_sel  <= !last_sel;
            end
            else if (req0 || req1)
            begin
                gnt_valid <= 1'b1;
                gnt_sel   <= req1;
                last_sel  <= req1;
            end
        end
        else if (s_rsp.ack || s_rsp.err)
        begin
            gnt_valid <= 1'b0;   // free again next cycle
        end
    end

    assign s_req  = !gnt_valid ? '0 : (gnt_sel ? m1_req : m0_req);
    assign m0_rsp = (gnt_valid && !gnt_sel) ? s_rsp : '0;
    assign m1_rsp = (gnt_valid && gnt_sel) ? s_rsp : '0;

    // an ack only reaches the granted master, and only while it still requests
    a_m0_ack_granted: assert property (@(posedge CLK) disable iff (RESET)
        m0_rsp.ack |-> gnt_valid && !gnt_sel && req0)
        else $error("wb_arbiter: m0 acked without grant or request");

    a_m1_ack_granted: assert property (@(posedge CLK) disable iff (RESET)
        m1_rsp.ack |-> gnt_valid && gnt_sel && req1)
        else $error("wb_arbiter: m1 acked without grant or request");

endmodule

// ==== hdl/eeprom_ctrl.sv ====
`timescale 1ns/1ps

module eeprom_ctrl (
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::wb_req_t  wb_req,
    output eeprom_pkg::wb_rsp_t  wb_rsp,
    output eeprom_pkg::i2c_cmd_e cmd,
    output eeprom_pkg::ee_byte_t tx_byte,
    output logic                 cmd_valid,
    input  logic                 ready,
    input  logic                 done,
    input  logic                 nack,
    input  eeprom_pkg::ee_byte_t rx_byte
);

    import eeprom_pkg::*;

    ctrl_state_e state;
    logic        issued;      // command of this state already handed over
    logic        nack_seen;
    logic        cmd_state;
    logic        req_we;
    ee_addr_t    req_adr;
    ee_byte_t    req_dat;
    ee_byte_t    rd_data;

    always_comb
    begin
        cmd       = CMD_WRITE;
        tx_byte   = '0;
        cmd_state = 1'b1;
        case (state)
            START, RESTART:
                cmd = CMD_START;
            CTRL_W:
                tx_byte = {EE_DEV_CODE, req_adr[10:8], 1'b0};
            ADDR:
                tx_byte = req_adr[7:0];
            DATA_W:
                tx_byte = req_dat;
            CTRL_R:
                tx_byte = {EE_DEV_CODE, req_adr[10:8], 1'b1};   // r/w = read
            DATA_R:
                cmd = CMD_READ;
            STOP:
                cmd = CMD_STOP;
            default:
                cmd_state = 1'b0;
        endcase
    end

    assign cmd_valid = cmd_state && !issued;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            issued    <= 1'b0;
            nack_seen <= 1'b0;
        end
        else
        begin
            if (cmd_valid)
                issued <= 1'b1;
            if (done)
                issued <= 1'b0;

            case (state)
                IDLE:
                    if (wb_req.cyc && wb_req.stb)
                    begin
                        nack_seen <= 1'b0;
                        state     <= START;
                    end
                START:
                    if (done)
                        state <= CTRL_W;
                CTRL_W, ADDR, CTRL_R:
                    if (done)
                    begin
                        if (nack)
                        begin
                            nack_seen <= 1'b1;   // abandon, close the bus
                            state     <= STOP;
                        end
                        else if (state == CTRL_R)
                            state <= DATA_R;
                        else if (state == CTRL_W)
                            state <= ADDR;
                        else
                            state <= req_we ? DATA_W : RESTART;
                    end
                DATA_W:
                    if (done)
                    begin
                        nack_seen <= nack;
                        state     <= STOP;
                    end
                RESTART:
                    if (done)
                        state <= CTRL_R;
                DATA_R, STOP:
                    if (done)
                        state <= (state == STOP) ? DONE : STOP;
                default:
                    state <= IDLE;   // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == IDLE && wb_req.cyc && wb_req.stb)
        begin
            req_we  <= wb_req.we;
            req_adr <= wb_req.adr;
            req_dat <= wb_req.dat;
        end
        if (state == DATA_R && done)
            rd_data <= rx_byte;
    end

    assign wb_rsp.ack = (state == DONE) && !nack_seen;
    assign wb_rsp.err = (state == DONE) && nack_seen;
    assign wb_rsp.dat = rd_data;

    // the response ends a request the master still holds
    a_rsp_excl: assert property (@(posedge CLK) disable iff (RESET)
        (wb_rsp.ack || wb_rsp.err) |-> (wb_rsp.ack != wb_rsp.err) && wb_req.cyc && wb_req.stb)
        else $error("eeprom_ctrl: ack/err overlap or no live request");

    a_cmd_ready: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |-> ready)
        else $error("eeprom_ctrl: command issued while bit engine busy");

endmodule

// ==== hdl/i2c_bit_engine.sv ====
`timescale 1ns/1ps

module i2c_bit_engine #(
    parameter int CLK_DIV = 4
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::i2c_cmd_e cmd,
    input  eeprom_pkg::ee_byte_t tx_byte,
    input  logic                 cmd_valid,
    output logic                 ready,
    output logic                 done,
    output logic                 nack,
    output eeprom_pkg::ee_byte_t rx_byte,
    output logic                 scl,
    output logic                 sda_oe,
    input  logic                 sda_in
);

    import eeprom_pkg::*;

    localparam int CNT_W = $clog2(CLK_DIV);

    logic [CNT_W-1:0] cnt;        // cycles within a half period
    logic [4:0]       phase;      // half period within the command
    logic [4:0]       last_phase;
    logic             busy;
    logic             tick;
    logic             accept;
    i2c_cmd_e         cmd_q;
    ee_byte_t         shreg;

    // scl level for each half period of a command
    function automatic logic scl_at(i2c_cmd_e c, logic [4:0] p);
        logic level;
        case (c)
            CMD_START: level = (p == 5'd1) || (p == 5'd2);
            CMD_STOP:  level = (p != 5'd0);
            default:   level = p[0];    // data bits, low then high
        endcase
        return level;
    endfunction

    assign tick       = (cnt == CNT_W'(CLK_DIV - 1));
    assign last_phase = (cmd_q == CMD_WRITE || cmd_q == CMD_READ) ? 5'd17 : 5'd3;
    assign done       = busy && tick && (phase == last_phase);
    assign ready      = !busy || done;
    assign accept     = cmd_valid && ready;
    assign rx_byte    = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy   <= 1'b0;
            phase  <= '0;
            cnt    <= '0;
            cmd_q  <= CMD_STOP;
            scl    <= 1'b1;
            sda_oe <= 1'b0;
            nack   <= 1'b0;
        end
        else if (accept)
        begin
            busy  <= 1'b1;
            phase <= '0;
            cnt   <= '0;
            cmd_q <= cmd;
            scl   <= scl_at(cmd, 5'd0);
        end
        else if (busy)
        begin
            cnt <= tick ? '0 : cnt + 1'b1;
            if (tick)
            begin
                if (phase == last_phase)
                    busy <= 1'b0;
                else
                begin
                    phase <= phase + 5'd1;
                    scl   <= scl_at(cmd_q, phase + 5'd1);
                end
            end
            // sda moves one clock after scl falls
            if (cnt == '0 && !phase[0] && (phase != 5'd2 || cmd_q == CMD_WRITE))
            begin
                case (cmd_q)
                    CMD_START: sda_oe <= 1'b0;
                    CMD_STOP:  sda_oe <= 1'b1;
                    CMD_WRITE: sda_oe <= (phase < 5'd16) ? !shreg[7] : 1'b0;
                    default:   sda_oe <= 1'b0;   // read and the nack bit
                endcase
            end
            if (tick && phase == 5'd1 && (cmd_q == CMD_START || cmd_q == CMD_STOP))
                sda_oe <= (cmd_q == CMD_START);  // the start/stop edge itself
            if (cnt == '0 && phase == 5'd17 && cmd_q == CMD_WRITE)
                nack <= sda_in;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
            shreg <= tx_byte;
        else if (busy && cmd_q == CMD_WRITE && tick && phase[0])
            shreg <= {shreg[6:0], 1'b0};
        else if (busy && cmd_q == CMD_READ && cnt == '0 && phase[0] && phase < 5'd16)
            shreg <= {shreg[6:0], sda_in};   // msb first
    end

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !(cmd_q inside {CMD_START, CMD_STOP})) |-> $stable(sda_in))
        else $error("i2c_bit_engine: sda changed while scl high");

endmodule

// ==== hdl/eeprom_sys.sv ====
`timescale 1ns/1ps

module eeprom_sys #(
    parameter int CLK_DIV = 4
) (
    input  logic                CLK,
    input  logic                RESET,
    input  eeprom_pkg::wb_req_t m0_req,
    input  eeprom_pkg::wb_req_t m1_req,
    output eeprom_pkg::wb_rsp_t m0_rsp,
    output eeprom_pkg::wb_rsp_t m1_rsp,
    output logic                scl,
    inout  wire                 sda
);

    import eeprom_pkg::*;

    wb_req_t  s_req;
    wb_rsp_t  s_rsp;
    i2c_cmd_e cmd;
    ee_byte_t tx_byte;
    ee_byte_t rx_byte;
    logic     cmd_valid;
    logic     ready;
    logic     done;
    logic     nack;
    logic     sda_oe;
    logic     sda_in;

    wb_arbiter wb_arbiter_inst (
        .CLK    (CLK),
        .RESET  (RESET),
        .m0_req (m0_req),
        .m1_req (m1_req),
        .m0_rsp (m0_rsp),
        .m1_rsp (m1_rsp),
        .s_req  (s_req),
        .s_rsp  (s_rsp)
    );

    eeprom_ctrl eeprom_ctrl_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .wb_req    (s_req),
        .wb_rsp    (s_rsp),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .cmd_valid (cmd_valid),
        .ready     (ready),
        .done      (done),
        .nack      (nack),
        .rx_byte   (rx_byte)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) i2c_bit_engine_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .cmd_valid (cmd_valid),
        .ready     (ready),
        .done      (done),
        .nack      (nack),
        .rx_byte   (rx_byte),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

    // open drain, pulled up outside
    assign sda    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = sda;

endmodule

// ==== bench/eeprom_model.sv ====
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    input  logic refuse
);

    localparam int M_IDLE  = 0;
    localparam int M_CTRL  = 1;
    localparam int M_ADDR  = 2;
    localparam int M_WDATA = 3;
    localparam int M_RDATA = 4;

    logic [7:0] mem [0:2047];
    int         mode;
    int         edges;        // scl rises within the current byte
    logic       drive_low;
    logic       acked;        // answer given to the last byte
    logic       rd;
    logic [2:0] hi;           // page bits from the control byte
    logic [7:0] lo;
    logic [7:0] rx;
    logic [7:0] tx;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        mode      = M_IDLE;
        edges     = 0;
        drive_low = 1'b0;
        acked     = 1'b0;
        rd        = 1'b0;
        hi        = '0;
        lo        = '0;
        rx        = '0;
        tx        = '0;
        for (int a = 0; a < 2048; a++)
            mem[a] = 8'hff;   // erased
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            mode      = M_CTRL;
            edges     = 0;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            mode      = M_IDLE;   // stop
            edges     = 0;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (mode != M_IDLE)
        begin
            if (edges < 8)
                rx = {rx[6:0], sda !== 1'b0};
            edges = edges + 1;
        end
    end

    // sda only moves while scl is low
    always @(negedge scl)
    begin
        if (mode != M_IDLE)
        begin
            if (edges == 8 && mode == M_RDATA)
                drive_low = 1'b0;   // master answers this bit
            else if (edges == 8)
            begin
                acked = !refuse;
                case (mode)
                    M_CTRL:
                        if (rx[7:4] != 4'b1010)
                            acked = 1'b0;
                        else
                        begin
                            hi = rx[3:1];
                            rd = rx[0];
                        end
                    M_ADDR:
                        lo = rx;
                    default:
                        if (acked)
                            mem[{hi, lo}] = rx;
                endcase
                drive_low = acked;
            end
            else if (edges == 9)
            begin
                edges     = 0;
                drive_low = 1'b0;
                if (!acked || mode == M_WDATA || mode == M_RDATA)
                    mode = M_IDLE;   // wait for the stop
                else if (mode == M_ADDR)
                    mode = M_WDATA;
                else if (rd)
                begin
                    mode      = M_RDATA;
                    tx        = mem[{hi, lo}];
                    drive_low = !tx[7];
                end
                else
                    mode = M_ADDR;
            end
            else if (mode == M_RDATA)
                drive_low = !tx[7 - edges];   // msb first
        end
    end

endmodule

// ==== bench/tb_eeprom_sys.sv ====
`timescale 1ns/1ps

module tb_eeprom_sys;

    import eeprom_pkg::*;

    localparam int N_WR     = 12;   // single-master writes, then as many reads
    localparam int N_SHARED = 6;
    localparam int N_CONC   = 8;    // writes per master when both compete
    localparam int N_REFUSE = 3;
    localparam int N_TRANS  = 2 * N_WR + 4 * N_SHARED + 4 * N_CONC + 2 * N_REFUSE + 2;

    logic        CLK;
    logic        RESET;
    wb_req_t     m0_req;
    wb_req_t     m1_req;
    wb_rsp_t     m0_rsp;
    wb_rsp_t     m1_rsp;
    logic        scl;
    wire         sda;
    logic        refuse;

    ee_byte_t    ref_mem [0:2047];
    ee_addr_t    written_q [$];
    logic        done_order [$];   // master index of each finished access
    int          data_errors;
    int          rsp_errors;
    int          bus_errors;
    int unsigned cycle_count;

    pullup (sda);

    eeprom_sys eeprom_sys_inst (
        .CLK    (CLK),
        .RESET  (RESET),
        .m0_req (m0_req),
        .m1_req (m1_req),
        .m0_rsp (m0_rsp),
        .m1_rsp (m1_rsp),
        .scl    (scl),
        .sda    (sda)
    );

    eeprom_model eeprom_model_inst (
        .scl    (scl),
        .sda    (sda),
        .refuse (refuse)
    );

    always #50 CLK = !CLK;

    always @(posedge CLK)
        cycle_count <= cycle_count + 1;

    task automatic check_byte(input string name, input ee_byte_t expected,
                              input ee_byte_t actual);
        if (expected !== actual)
        begin
            data_errors++;
            $display("[ERROR] %s: expected %02h, actual %02h", name, expected, actual);
        end
    endtask

    task automatic check_rsp(input string name, input wb_rsp_t expected,
                             input wb_rsp_t actual);
        if (expected.ack !== actual.ack || expected.err !== actual.err)
        begin
            rsp_errors++;
            $display("[ERROR] %s: expected ack=%0b err=%0b, actual ack=%0b err=%0b",
                     name, expected.ack, expected.err, actual.ack, actual.err);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            bus_errors++;
            $display("[ERROR] %s: expected %0b, actual %0b", name, expected, actual);
        end
    endtask

    task automatic drive_req(input int m, input wb_req_t req);
        if (m == 0)
            m0_req = req;
        else
            m1_req = req;
    endtask

    // entered 1 ns after a rising edge, left at the same point
    task automatic wb_access(input int m, input logic we, input ee_addr_t adr,
                             input ee_byte_t dat, output wb_rsp_t rsp);
        wb_req_t req;
        wb_rsp_t cur;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = dat;
        drive_req(m, req);
        do
        begin
            @(posedge CLK);
            #1;
            cur = (m == 0) ? m0_rsp : m1_rsp;
        end
        while (cur.ack !== 1'b1 && cur.err !== 1'b1);
        rsp = cur;
        done_order.push_back(m == 1);
        @(posedge CLK);   // request held through the acknowledging edge
        #1;
        drive_req(m, '0);
    endtask

    task automatic write_byte(input string name, input int m, input ee_addr_t adr,
                              input ee_byte_t dat, input logic expect_ack);
        wb_rsp_t rsp;
        wb_rsp_t exp;
        exp.ack = expect_ack;
        exp.err = !expect_ack;
        exp.dat = '0;
        wb_access(m, 1'b1, adr, dat, rsp);
        check_rsp(name, exp, rsp);
        if (rsp.ack === 1'b1)
            ref_mem[adr] = dat;
    endtask

    task automatic read_byte(input string name, input int m, input ee_addr_t adr,
                             input logic expect_ack);
        wb_rsp_t rsp;
        wb_rsp_t exp;
        exp.ack = expect_ack;
        exp.err = !expect_ack;
        exp.dat = '0;
        wb_access(m, 1'b0, adr, 8'h00, rsp);
        check_rsp(name, exp, rsp);
        if (expect_ack && rsp.ack === 1'b1)
            check_byte(name, ref_mem[adr], rsp.dat);
    endtask

    task automatic print_error_counts();
        $display("errors: data %0d, response %0d, bus %0d",
                 data_errors, rsp_errors, bus_errors);
    endtask

    initial
    begin : main
        wb_rsp_t  idle_rsp;
        ee_addr_t adr;
        ee_byte_t dat;
        ee_addr_t cc_adr [2][N_CONC];
        ee_byte_t cc_dat [2][N_CONC];

        void'($urandom(32'h24f10f75));
        CLK         = 1'b0;
        RESET       = 1'b1;
        m0_req      = '0;
        m1_req      = '0;
        refuse      = 1'b0;
        cycle_count = 0;
        data_errors = 0;
        rsp_errors  = 0;
        bus_errors  = 0;
        idle_rsp    = '0;
        for (int a = 0; a < 2048; a++)
            ref_mem[a] = 8'hff;

        repeat (10) @(posedge CLK);
        #1;
        RESET = 1'b0;

        check_bit("reset scl", 1'b1, scl);
        check_bit("reset sda", 1'b1, sda);
        check_rsp("reset m0", idle_rsp, m0_rsp);
        check_rsp("reset m1", idle_rsp, m1_rsp);

        for (int i = 0; i < N_WR; i++)
        begin
            adr = $urandom % 2048;
            dat = $urandom % 256;
            written_q.push_back(adr);
            write_byte("single write", 0, adr, dat, 1'b1);
        end
        for (int i = 0; i < N_WR; i++)
        begin
            if (i % 2 == 0)
                adr = written_q[$urandom % written_q.size()];
            else
                adr = $urandom % 2048;   // most likely still erased
            read_byte("single read", 0, adr, 1'b1);
        end

        for (int i = 0; i < N_SHARED; i++)
        begin
            adr = $urandom % 2048;
            dat = $urandom % 256;
            write_byte("shared write m1", 1, adr, dat, 1'b1);
            read_byte("shared read m0", 0, adr, 1'b1);
            adr = $urandom % 2048;
            dat = $urandom % 256;
            write_byte("shared write m0", 0, adr, dat, 1'b1);
            read_byte("shared read m1", 1, adr, 1'b1);
        end

        // m0 in the lower half, m1 in the upper half
        for (int i = 0; i < N_CONC; i++)
        begin
            cc_adr[0][i] = $urandom % 1024;
            cc_adr[1][i] = 1024 + $urandom % 1024;
            cc_dat[0][i] = $urandom % 256;
            cc_dat[1][i] = $urandom % 256;
        end
        done_order.delete();
        fork
            for (int i = 0; i < N_CONC; i++)
                write_byte("concurrent write m0", 0, cc_adr[0][i], cc_dat[0][i], 1'b1);
            for (int i = 0; i < N_CONC; i++)
                write_byte("concurrent write m1", 1, cc_adr[1][i], cc_dat[1][i], 1'b1);
        join
        for (int i = 1; i < done_order.size(); i++)
            check_bit("alternating ack", !done_order[i - 1], done_order[i]);
        for (int i = 0; i < N_CONC; i++)
        begin
            read_byte("concurrent read m0", 0, cc_adr[0][i], 1'b1);
            read_byte("concurrent read m1", 1, cc_adr[1][i], 1'b1);
        end

        for (int i = 0; i < N_REFUSE; i++)
        begin
            adr    = written_q[i];
            refuse = 1'b1;
            write_byte("refused write", 0, adr, ~ref_mem[adr], 1'b0);
            refuse = 1'b0;
            read_byte("read after refused write", 0, adr, 1'b1);
        end
        refuse = 1'b1;
        read_byte("refused read", 1, written_q[0], 1'b0);
        refuse = 1'b0;
        read_byte("read after refused read", 1, written_q[0], 1'b1);

        print_error_counts();
        if (data_errors + rsp_errors + bus_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial
    begin : watchdog
        int limit;
        limit = N_TRANS * 70 * eeprom_sys_inst.CLK_DIV * 2 + 1000;
        wait (cycle_count >= limit);
        $display("timeout: run did not finish within %0d cycles, controller in state %s",
                 limit, eeprom_sys_inst.eeprom_ctrl_inst.state.name());
        print_error_counts();
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/eeprom_pkg.sv
hdl/wb_arbiter.sv
hdl/eeprom_ctrl.sv
hdl/i2c_bit_engine.sv
hdl/eeprom_sys.sv
bench/eeprom_model.sv
bench/tb_eeprom_sys.sv
